// ==== xcvr_reset_params.svh ====
// Channel count, synchronizer depth and reset periods for the transceiver reset sequencer
`ifndef XCVR_RESET_PARAMS_SVH
`define XCVR_RESET_PARAMS_SVH

// **************************************************
// Structure
// **************************************************

// Channels sharing the one TX PLL
`define XRC_CHANNELS 2

// Flip-flops per status synchronizer
`define XRC_SYNC_STAGES 2

// **************************************************
// Reset periods, all in clock cycles
// **************************************************

// PLL held in powerdown after reset
`define XRC_T_PLL_POWERDOWN 8
// TX PCS reset after its last request
`define XRC_T_TX_DIGITALRESET 4
// RX PMA reset after calibration ends
`define XRC_T_RX_ANALOGRESET 4
// RX PCS reset after lock to data
`define XRC_T_RX_DIGITALRESET 12
// Digital reset release to ready
`define XRC_T_READY 3

`endif

// ==== xcvr_reset_pkg.sv ====
// Channel control, synchronized status and reset output struct types
`default_nettype none

package xcvr_reset_pkg;

  // **************************************************
  // Per-channel ports of the top level
  // **************************************************

  // One channel's inputs, 7 bits
  typedef struct packed {
    logic tx_cal_busy;         // TX calibration in progress
    logic tx_manual;           // Ignore loss of PLL lock
    logic tx_digitalreset_or;  // Force TX PCS reset
    logic rx_is_lockedtodata;  // CDR locked to incoming data
    logic rx_cal_busy;         // RX calibration in progress
    logic rx_manual;           // Ignore loss of lock to data
    logic rx_digitalreset_or;  // Force RX PCS reset
  } chan_ctrl_t;

  // One channel's outputs, 6 bits
  typedef struct packed {
    logic tx_analogreset;   // TX PMA
    logic tx_digitalreset;  // TX PCS
    logic tx_ready;         // TX out of reset
    logic rx_analogreset;   // RX PMA
    logic rx_digitalreset;  // RX PCS
    logic rx_ready;         // RX out of reset
  } chan_reset_t;

  // **************************************************
  // Status after synchronization
  // **************************************************

  typedef struct packed {
    logic cal_busy;
    logic manual;
    logic pll_locked;  // Shared PLL, retimed per channel
  } tx_status_t;

  typedef struct packed {
    logic cal_busy;      // Resets high so RX starts in analog reset
    logic lockedtodata;
    logic manual;
  } rx_status_t;

endpackage

`default_nettype wire

// ==== status_sync.sv ====
// Multi-stage synchronizer for one packed status struct with a typed reset value
`default_nettype none
`timescale 1ns/1ns
`include "xcvr_reset_params.svh"

module status_sync #(
  parameter type     status_t   = logic,
  parameter status_t init_value = status_t'(0)
) (
  input  wire          clock,
  input  wire          reset_sync,
  input  wire status_t d,          // Asynchronous status
  output status_t      q           // Retimed status
);

  // Stage 0 samples d, last stage drives q
  status_t stage [`XRC_SYNC_STAGES];

  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      for (int i = 0; i < `XRC_SYNC_STAGES; i++) begin
        stage[i] <= init_value;
      end
    end else begin
      stage[0] <= d;
      for (int i = 1; i < `XRC_SYNC_STAGES; i++) begin
        stage[i] <= stage[i-1];  // Shift one stage per edge
      end
    end
  end

  assign q = stage[`XRC_SYNC_STAGES-1];

  // Unknown status would feed straight into the reset requests
  a_q_known: assert property (
    @(posedge clock) disable iff (reset_sync)
    !$isunknown(q)
  ) else $error("status_sync: q unknown after reset");

endmodule

`default_nettype wire

// ==== reset_counter.sv ====
// Timed reset generator with synchronous request and combinational override
`default_nettype none
`timescale 1ns/1ns

module reset_counter #(
  parameter int period = 4  // Cycles of busy after request drops
) (
  input  wire  clock,
  input  wire  reset_sync,
  input  wire  request,    // Synchronous reset request
  input  wire  override,   // Merged into reset_out only
  output logic reset_out,
  output logic busy        // Request or timed period in progress
);

  // **************************************************
  // Counter sizing
  // **************************************************

  localparam int cnt_w = $clog2(period + 1);
  // Value seen on the edge that ends the period
  localparam logic [cnt_w-1:0] last_count = cnt_w'(period - 1);

  logic [cnt_w-1:0] count;

  // **************************************************
  // Saturating count
  // **************************************************

  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      count <= '0;
      busy  <= 1'b1;  // Start up in reset
    end else if (request) begin
      // Restart the period
      count <= '0;
      busy  <= 1'b1;
    end else if (busy) begin
      count <= count + 1'b1;
      if (count == last_count) begin
        busy <= 1'b0;  // T-th quiet edge
      end
    end
    // Idle once busy drops, count parks at period
  end

  // Override never touches busy, so downstream timers keep running
  assign reset_out = busy | override;

  // **************************************************
  // Checks
  // **************************************************

  // Busy ends only on a quiet edge that closes a full request-free period
  a_busy_full_period: assert property (
    @(posedge clock) disable iff (reset_sync)
    $fell(busy) |-> $past(!request) && $past(!request, period)
  ) else $error("reset_counter: busy ended during or too soon after a request");

endmodule

`default_nettype wire

// ==== tx_reset_channel.sv ====
// TX reset sequencing for one channel with status sync, first-lock latch and ready delay
`default_nettype none
`timescale 1ns/1ns
`include "xcvr_reset_params.svh"

module tx_reset_channel
  import xcvr_reset_pkg::*;
(
  input  wire             clock,
  input  wire             reset_sync,
  input  wire             pll_powerdown,  // From the shared PLL counter
  input  wire             pll_locked,     // Shared PLL lock, asynchronous
  input  wire chan_ctrl_t ctrl,
  output logic            tx_analogreset,
  output logic            tx_digitalreset,
  output logic            tx_ready
);

  tx_status_t tx_raw;      // Status before retiming
  tx_status_t tx_sync;
  logic       lock_latch;  // Set on first lock outside calibration
  logic       dig_request;
  logic       dig_busy;
  logic       ready_reset;

  // PMA reset tracks the PLL
  assign tx_analogreset = pll_powerdown;

  // **************************************************
  // Status synchronization
  // **************************************************

  assign tx_raw = '{cal_busy: ctrl.tx_cal_busy, manual: ctrl.tx_manual, pll_locked: pll_locked};

  status_sync #(
    .status_t   (tx_status_t),
    .init_value (tx_status_t'(0))
  ) sync_tx_status (
    .clock      (clock),
    .reset_sync (reset_sync),
    .d          (tx_raw),
    .q          (tx_sync)
  );

  // One-shot, only reset clears it
  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      lock_latch <= 1'b0;
    end else if (tx_sync.pll_locked && !tx_sync.cal_busy) begin
      lock_latch <= 1'b1;
    end
  end

  // **************************************************
  // Digital reset and ready
  // **************************************************

  assign dig_request = pll_powerdown
                     | tx_sync.cal_busy
                     | ~lock_latch                             // No first lock yet
                     | (~tx_sync.pll_locked & ~tx_sync.manual); // Auto restart on lock loss

  reset_counter #(.period(`XRC_T_TX_DIGITALRESET)) counter_digital (
    .clock      (clock),
    .reset_sync (reset_sync),
    .request    (dig_request),
    .override   (ctrl.tx_digitalreset_or),
    .reset_out  (tx_digitalreset),
    .busy       (dig_busy)
  );

  // Timer restarts on busy, PCS reset masks ready at once
  reset_counter #(.period(`XRC_T_READY)) counter_ready (
    .clock      (clock),
    .reset_sync (reset_sync),
    .request    (dig_busy),
    .override   (tx_digitalreset),
    .reset_out  (ready_reset),
    .busy       ()
  );

  assign tx_ready = ~ready_reset;

  // Ready only once the PLL has locked outside calibration
  a_ready_after_lock: assert property (
    @(posedge clock) disable iff (reset_sync)
    tx_ready |-> lock_latch
  ) else $error("tx_reset_channel: tx_ready high before first lock");

endmodule

`default_nettype wire

// ==== rx_reset_channel.sv ====
// RX reset sequencing for one channel with status sync, analog, digital and ready timers
`default_nettype none
`timescale 1ns/1ns
`include "xcvr_reset_params.svh"

module rx_reset_channel
  import xcvr_reset_pkg::*;
(
  input  wire             clock,
  input  wire             reset_sync,
  input  wire chan_ctrl_t ctrl,
  output logic            rx_analogreset,
  output logic            rx_digitalreset,
  output logic            rx_ready
);

  // Calibration assumed busy until the first real sample
  localparam rx_status_t rx_sync_init = '{cal_busy: 1'b1, lockedtodata: 1'b0, manual: 1'b0};

  rx_status_t rx_raw;
  rx_status_t rx_sync;
  logic       ana_busy;
  logic       dig_request;
  logic       dig_busy;
  logic       ready_reset;

  // **************************************************
  // Status synchronization
  // **************************************************

  assign rx_raw = '{
    cal_busy:     ctrl.rx_cal_busy,
    lockedtodata: ctrl.rx_is_lockedtodata,
    manual:       ctrl.rx_manual
  };

  status_sync #(
    .status_t   (rx_status_t),
    .init_value (rx_sync_init)
  ) sync_rx_status (
    .clock      (clock),
    .reset_sync (reset_sync),
    .d          (rx_raw),
    .q          (rx_sync)
  );

  // **************************************************
  // Analog, digital and ready timers
  // **************************************************

  // PMA reset during calibration and a fixed time after
  reset_counter #(.period(`XRC_T_RX_ANALOGRESET)) counter_analog (
    .clock      (clock),
    .reset_sync (reset_sync),
    .request    (rx_sync.cal_busy),
    .override   (1'b0),
    .reset_out  (rx_analogreset),
    .busy       (ana_busy)
  );

  assign dig_request = rx_sync.cal_busy
                     | ana_busy
                     | (~rx_sync.lockedtodata & ~rx_sync.manual);  // Auto restart

  reset_counter #(.period(`XRC_T_RX_DIGITALRESET)) counter_digital (
    .clock      (clock),
    .reset_sync (reset_sync),
    .request    (dig_request),
    .override   (ctrl.rx_digitalreset_or),
    .reset_out  (rx_digitalreset),
    .busy       (dig_busy)
  );

  // Same ready scheme as TX
  reset_counter #(.period(`XRC_T_READY)) counter_ready (
    .clock      (clock),
    .reset_sync (reset_sync),
    .request    (dig_busy),
    .override   (rx_digitalreset),
    .reset_out  (ready_reset),
    .busy       ()
  );

  assign rx_ready = ~ready_reset;

  // PCS must never leave reset before the PMA
  a_analog_within_digital: assert property (
    @(posedge clock) disable iff (reset_sync)
    rx_analogreset |-> rx_digitalreset
  ) else $error("rx_reset_channel: rx_analogreset without rx_digitalreset");

endmodule

`default_nettype wire

// ==== xcvr_reset_control.sv ====
// Top level of the transceiver reset sequencer with PLL powerdown and per-channel TX and RX
`default_nettype none
`timescale 1ns/1ns
`include "xcvr_reset_params.svh"

module xcvr_reset_control
  import xcvr_reset_pkg::*;
(
  input  wire                                   clock,
  input  wire                                   reset_sync,     // Already synchronized
  input  wire                                   pll_locked,     // Shared TX PLL lock
  input  wire chan_ctrl_t  [`XRC_CHANNELS-1:0]  ctrl,
  output logic                                  pll_powerdown,
  output wire chan_reset_t [`XRC_CHANNELS-1:0]  resets
);

  // **************************************************
  // TX PLL powerdown
  // **************************************************

  // Timed from reset alone, no other request source
  reset_counter #(.period(`XRC_T_PLL_POWERDOWN)) counter_pll_powerdown (
    .clock      (clock),
    .reset_sync (reset_sync),
    .request    (1'b0),
    .override   (1'b0),
    .reset_out  (pll_powerdown),
    .busy       ()
  );

  // **************************************************
  // Per-channel sequencers
  // **************************************************

  for (genvar ch = 0; ch < `XRC_CHANNELS; ch++) begin : g_chan

    // TX side sees the PLL, powerdown doubles as PMA reset
    tx_reset_channel u_tx (
      .clock           (clock),
      .reset_sync      (reset_sync),
      .pll_powerdown   (pll_powerdown),
      .pll_locked      (pll_locked),
      .ctrl            (ctrl[ch]),
      .tx_analogreset  (resets[ch].tx_analogreset),
      .tx_digitalreset (resets[ch].tx_digitalreset),
      .tx_ready        (resets[ch].tx_ready)
    );

    // RX side independent of the PLL
    rx_reset_channel u_rx (
      .clock           (clock),
      .reset_sync      (reset_sync),
      .ctrl            (ctrl[ch]),
      .rx_analogreset  (resets[ch].rx_analogreset),
      .rx_digitalreset (resets[ch].rx_digitalreset),
      .rx_ready        (resets[ch].rx_ready)
    );

  end

endmodule

`default_nettype wire

// ==== tb_reset_checks.sv ====
// Checker with reference counters and concurrent assertions for the transceiver reset sequencer
`default_nettype none
`timescale 1ns/1ns
`include "xcvr_reset_params.svh"

module tb_reset_checks
  import xcvr_reset_pkg::*;
(
  input  wire                                  clock,
  input  wire                                  reset_sync,
  input  wire                                  pll_locked,
  input  wire chan_ctrl_t  [`XRC_CHANNELS-1:0] ctrl,
  input  wire                                  pll_powerdown,
  input  wire chan_reset_t [`XRC_CHANNELS-1:0] resets,
  output logic                                 failed      // Set by the first failing check
);

  localparam int tx_bound = 2 + 1 + `XRC_T_TX_DIGITALRESET + `XRC_T_READY + 2;
  localparam int rx_bound = 2 + 1 + `XRC_T_RX_ANALOGRESET + `XRC_T_RX_DIGITALRESET
                          + `XRC_T_READY + 2;
  localparam logic [5:0] ch1_up_value = 6'b001001;  // Both readies, no resets

  int   edge_cnt;   // Edges since reset release
  logic lock_seen;
  logic pll_prev, cal_prev, dlock_prev;
  int   tx_wait, tx_drop, tx_hold;  // Channel 0 TX reference counters
  int   rx_wait, rx_drop, rx_hold, ana_wait;
  logic ch1_up;     // Channel 1 reached its steady state

  initial failed = 1'b0;

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("Mismatch at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
    failed = 1'b1;
  endtask

  // **************************************************
  // Reference counters
  // **************************************************

  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      edge_cnt <= 0;
      lock_seen <= 1'b0;
      pll_prev <= pll_locked;
      cal_prev <= ctrl[0].rx_cal_busy;
      dlock_prev <= ctrl[0].rx_is_lockedtodata;
      {tx_wait, tx_drop, tx_hold} <= '0;
      {rx_wait, rx_drop, rx_hold, ana_wait} <= '0;
      ch1_up <= 1'b0;
    end else begin
      if (edge_cnt < 1000) edge_cnt <= edge_cnt + 1;  // Saturate
      if (pll_locked) lock_seen <= 1'b1;
      pll_prev <= pll_locked;
      cal_prev <= ctrl[0].rx_cal_busy;
      dlock_prev <= ctrl[0].rx_is_lockedtodata;
      if (resets[1] == ch1_up_value) ch1_up <= 1'b1;
      // TX lock gained, ready expected within the bound
      if (!pll_prev && pll_locked && !pll_powerdown) tx_wait <= 1;
      else if (tx_wait != 0) tx_wait <= resets[0].tx_ready ? 0 : tx_wait + 1;
      // TX lock lost in auto mode
      if (pll_prev && !pll_locked && !ctrl[0].tx_manual) tx_drop <= 1;
      else if (tx_drop != 0) tx_drop <= resets[0].tx_digitalreset ? 0 : tx_drop + 1;
      // TX lock lost in manual mode, ready must hold
      if (pll_prev && !pll_locked && ctrl[0].tx_manual && resets[0].tx_ready) tx_hold <= 8;
      else if (tx_hold != 0) tx_hold <= tx_hold - 1;
      // RX calibration start
      if (!cal_prev && ctrl[0].rx_cal_busy) ana_wait <= 1;
      else if (ana_wait != 0) ana_wait <= resets[0].rx_analogreset ? 0 : ana_wait + 1;
      // RX calibration end or lock regained
      if ((cal_prev && !ctrl[0].rx_cal_busy && ctrl[0].rx_is_lockedtodata) ||
          (!dlock_prev && ctrl[0].rx_is_lockedtodata && !ctrl[0].rx_cal_busy)) begin
        rx_wait <= 1;
      end else if (rx_wait != 0) begin
        rx_wait <= resets[0].rx_ready ? 0 : rx_wait + 1;
      end
      if (dlock_prev && !ctrl[0].rx_is_lockedtodata && !ctrl[0].rx_manual) rx_drop <= 1;
      else if (rx_drop != 0) rx_drop <= resets[0].rx_digitalreset ? 0 : rx_drop + 1;
      if (dlock_prev && !ctrl[0].rx_is_lockedtodata && ctrl[0].rx_manual
          && resets[0].rx_ready) rx_hold <= 8;
      else if (rx_hold != 0) rx_hold <= rx_hold - 1;
    end
  end

  // **************************************************
  // Assertions
  // **************************************************

  a_pd_high: assert property (@(posedge clock) disable iff (reset_sync)
    (edge_cnt < `XRC_T_PLL_POWERDOWN) |-> pll_powerdown)
    else mismatch("pll_powerdown", 1, $sampled(pll_powerdown));
  a_pd_low: assert property (@(posedge clock) disable iff (reset_sync)
    (edge_cnt >= `XRC_T_PLL_POWERDOWN) |-> !pll_powerdown)
    else mismatch("pll_powerdown", 0, $sampled(pll_powerdown));
  a_tx_bringup: assert property (@(posedge clock) disable iff (reset_sync) tx_wait <= tx_bound)
    else mismatch("tx_ready wait cycles", tx_bound, $sampled(tx_wait));
  a_tx_drop: assert property (@(posedge clock) disable iff (reset_sync) tx_drop <= 3)
    else mismatch("tx_digitalreset wait cycles", 3, $sampled(tx_drop));
  a_tx_hold: assert property (@(posedge clock) disable iff (reset_sync)
    (tx_hold != 0) |-> resets[0].tx_ready)
    else mismatch("resets[0].tx_ready", 1, $sampled(resets[0].tx_ready));
  a_rx_cal: assert property (@(posedge clock) disable iff (reset_sync) ana_wait <= 3)
    else mismatch("rx_analogreset wait cycles", 3, $sampled(ana_wait));
  a_rx_bringup: assert property (@(posedge clock) disable iff (reset_sync) rx_wait <= rx_bound)
    else mismatch("rx_ready wait cycles", rx_bound, $sampled(rx_wait));
  a_rx_drop: assert property (@(posedge clock) disable iff (reset_sync) rx_drop <= 3)
    else mismatch("rx_digitalreset wait cycles", 3, $sampled(rx_drop));
  a_rx_hold: assert property (@(posedge clock) disable iff (reset_sync)
    (rx_hold != 0) |-> resets[0].rx_ready)
    else mismatch("resets[0].rx_ready", 1, $sampled(resets[0].rx_ready));
  a_ch1_steady: assert property (@(posedge clock) disable iff (reset_sync)
    ch1_up |-> (resets[1] == ch1_up_value))
    else mismatch("resets[1]", ch1_up_value, $sampled(resets[1]));

  // Rules that hold on every channel
  for (genvar ch = 0; ch < `XRC_CHANNELS; ch++) begin : g_chan_checks
    a_reset_state: assert property (@(posedge clock) disable iff (reset_sync)
      (edge_cnt == 0) |-> (resets[ch] == 6'b110110))
      else mismatch($sformatf("resets[%0d] after reset", ch), 6'b110110,
                    $sampled(resets[ch]));
    a_tx_analog: assert property (@(posedge clock) disable iff (reset_sync)
      resets[ch].tx_analogreset == pll_powerdown)
      else mismatch("tx_analogreset", $sampled(pll_powerdown),
                    $sampled(resets[ch].tx_analogreset));
    a_no_lock: assert property (@(posedge clock) disable iff (reset_sync)
      !lock_seen |-> !resets[ch].tx_ready)
      else mismatch("tx_ready before lock", 0, $sampled(resets[ch].tx_ready));
    a_tx_or: assert property (@(posedge clock) disable iff (reset_sync)
      ctrl[ch].tx_digitalreset_or |-> resets[ch].tx_digitalreset)
      else mismatch("tx_digitalreset on override", 1, $sampled(resets[ch].tx_digitalreset));
    a_rx_or: assert property (@(posedge clock) disable iff (reset_sync)
      ctrl[ch].rx_digitalreset_or |-> resets[ch].rx_digitalreset)
      else mismatch("rx_digitalreset on override", 1, $sampled(resets[ch].rx_digitalreset));
    a_tx_ready: assert property (@(posedge clock) disable iff (reset_sync)
      resets[ch].tx_ready |-> !resets[ch].tx_digitalreset)
      else mismatch("tx_digitalreset with tx_ready", 0, $sampled(resets[ch].tx_digitalreset));
    a_rx_ready: assert property (@(posedge clock) disable iff (reset_sync)
      resets[ch].rx_ready |-> !resets[ch].rx_digitalreset)
      else mismatch("rx_digitalreset with rx_ready", 0, $sampled(resets[ch].rx_digitalreset));
    a_rx_order: assert property (@(posedge clock) disable iff (reset_sync)
      resets[ch].rx_analogreset |-> resets[ch].rx_digitalreset)
      else mismatch("rx_digitalreset with rx_analogreset", 1,
                    $sampled(resets[ch].rx_digitalreset));
  end

endmodule

`default_nettype wire

// ==== tb_xcvr_reset_control.sv ====
// Testbench top with clock, reset, seeded calibration pulses and timed waits
`default_nettype none
`timescale 1ns/1ns
`include "xcvr_reset_params.svh"

module tb_xcvr_reset_control
  import xcvr_reset_pkg::*;
;

  // Probe selectors for wait_for
  localparam int sel_tx_ready = 0;
  localparam int sel_tx_dig   = 1;
  localparam int sel_rx_ready = 2;
  localparam int sel_rx_dig   = 3;
  localparam int sel_ch1_up   = 4;

  logic                              clock;
  logic                              reset_sync;
  logic                              pll_locked;
  chan_ctrl_t  [`XRC_CHANNELS-1:0]   ctrl;
  logic                              pll_powerdown;
  chan_reset_t [`XRC_CHANNELS-1:0]   resets;
  logic                              failed;
  integer                            seed;
  int                                len;

  xcvr_reset_control i_dut (
    .clock         (clock),
    .reset_sync    (reset_sync),
    .pll_locked    (pll_locked),
    .ctrl          (ctrl),
    .pll_powerdown (pll_powerdown),
    .resets        (resets)
  );

  tb_reset_checks i_checks (
    .clock         (clock),
    .reset_sync    (reset_sync),
    .pll_locked    (pll_locked),
    .ctrl          (ctrl),
    .pll_powerdown (pll_powerdown),
    .resets        (resets),
    .failed        (failed)
  );

  always #20 clock = ~clock;  // 40 ns period

  task automatic report_failure(input string why);
    $display("Error at %0t ns: %s", $time, why);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping");
  endtask

  always @(posedge failed) report_failure("a check in the checker failed");

  function automatic logic probe(input int sel);
    case (sel)
      sel_tx_ready: probe = resets[0].tx_ready;
      sel_tx_dig:   probe = resets[0].tx_digitalreset;
      sel_rx_ready: probe = resets[0].rx_ready;
      sel_rx_dig:   probe = resets[0].rx_digitalreset;
      default:      probe = resets[1].tx_ready & resets[1].rx_ready;
    endcase
  endfunction

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clock);
    end
  endtask

  // Poll on falling edges, give up after limit cycles
  task automatic wait_for(input int sel, input logic val, input int limit, input string what);
    int n;
    n = 0;
    while (probe(sel) !== val && n < limit) begin
      @(negedge clock);
      n++;
    end
    if (probe(sel) !== val) report_failure($sformatf("timeout waiting for %s", what));
  endtask

  initial begin
    seed = 32'h1e4a_bc0e;
    clock = 1'b0;
    reset_sync = 1'b1;
    pll_locked = 1'b0;
    ctrl = '0;
    ctrl[0].rx_is_lockedtodata = 1'b1;
    ctrl[1].rx_is_lockedtodata = 1'b1;
    ctrl[1].tx_manual = 1'b1;  // Channel 1 rides through PLL drops
    wait_cycles(5);
    reset_sync = 1'b0;

    // ************************************************
    // Powerdown, then TX bring-up on first lock
    // ************************************************
    wait_cycles(40);
    pll_locked = 1'b1;
    wait_for(sel_tx_ready, 1'b1, 20, "tx_ready after lock");
    wait_for(sel_rx_ready, 1'b1, 30, "rx_ready after start");
    wait_for(sel_ch1_up, 1'b1, 30, "channel 1 ready");

    // Lock loss in auto mode, then in manual mode
    pll_locked = 1'b0;
    wait_for(sel_tx_dig, 1'b1, 5, "tx_digitalreset on lock loss");
    wait_cycles(5);
    pll_locked = 1'b1;
    wait_for(sel_tx_ready, 1'b1, 20, "tx_ready after relock");
    ctrl[0].tx_manual = 1'b1;
    wait_cycles(3);
    pll_locked = 1'b0;
    wait_cycles(10);
    pll_locked = 1'b1;
    ctrl[0].tx_manual = 1'b0;
    wait_cycles(4);
    wait_for(sel_tx_ready, 1'b1, 20, "tx_ready after manual drop");

    // ************************************************
    // RX calibration pulses and lock to data
    // ************************************************
    for (int i = 0; i < 4; i++) begin
      len = 1 + ($unsigned($random(seed)) % 6);
      ctrl[0].rx_cal_busy = 1'b1;
      wait_cycles(len);
      ctrl[0].rx_cal_busy = 1'b0;
      // Short pulses reach the resets only after they end
      wait_for(sel_rx_ready, 1'b0, 5, "rx_ready drop on calibration");
      wait_for(sel_rx_ready, 1'b1, 30, "rx_ready after calibration");
    end
    ctrl[0].rx_is_lockedtodata = 1'b0;
    wait_for(sel_rx_dig, 1'b1, 5, "rx_digitalreset on loss of lock to data");
    wait_cycles(3);
    ctrl[0].rx_is_lockedtodata = 1'b1;
    wait_for(sel_rx_ready, 1'b1, 30, "rx_ready after relock");
    ctrl[0].rx_manual = 1'b1;
    wait_cycles(3);
    ctrl[0].rx_is_lockedtodata = 1'b0;
    wait_cycles(10);
    ctrl[0].rx_is_lockedtodata = 1'b1;
    ctrl[0].rx_manual = 1'b0;
    wait_cycles(3);
    wait_for(sel_rx_ready, 1'b1, 30, "rx_ready after manual drop");

    // Overrides, ready returns at once after release
    ctrl[0].tx_digitalreset_or = 1'b1;
    wait_cycles(3);
    ctrl[0].tx_digitalreset_or = 1'b0;
    wait_for(sel_tx_ready, 1'b1, 3, "tx_ready after override");
    ctrl[0].rx_digitalreset_or = 1'b1;
    wait_cycles(3);
    ctrl[0].rx_digitalreset_or = 1'b0;
    wait_for(sel_rx_ready, 1'b1, 3, "rx_ready after override");
    wait_cycles(5);

    if (failed) begin
      report_failure("checks failed during the run");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
xcvr_reset_pkg.sv
status_sync.sv
reset_counter.sv
tx_reset_channel.sv
rx_reset_channel.sv
xcvr_reset_control.sv
tb_reset_checks.sv
tb_xcvr_reset_control.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_xcvr_reset_control
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
